// File: hw/rv32i_types.sv
/* rv32i_types: shared encodings for the five-stage RV32I core.
   opcodes, ALU and branch operations, mux selects and the decoded control word */
package rv32i_types;

  // base opcodes of the supported subset
  typedef enum logic [6:0] {
    op_lui   = 7'b0110111,
    op_auipc = 7'b0010111,
    op_jal   = 7'b1101111,
    op_jalr  = 7'b1100111,
    op_br    = 7'b1100011,
    op_load  = 7'b0000011,
    op_store = 7'b0100011,
    op_imm   = 7'b0010011,
    op_reg   = 7'b0110011
  } rv32i_opcode;

  typedef enum logic [3:0] {
    alu_add,  // zero, so a bubble decodes to add
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b // lui
  } alu_ops;

  // values match the funct3 field of the branch encodings
  typedef enum logic [2:0] {
    beq  = 3'b000,
    bne  = 3'b001,
    blt  = 3'b100,
    bge  = 3'b101,
    bltu = 3'b110,
    bgeu = 3'b111
  } branch_funct3;

  typedef enum logic {alumux1_rs1, alumux1_pc} alumux1_sel;
  typedef enum logic {alumux2_rs2, alumux2_imm} alumux2_sel;
  typedef enum logic [1:0] {rfmux_alu, rfmux_load, rfmux_pc_plus4} regfilemux_sel;
  typedef enum logic [1:0] {pcmux_pc_plus4, pcmux_target, pcmux_jalr} pcmux_sel;
  typedef enum logic [1:0] {fwd_rf, fwd_exmem, fwd_memwb} fwd_sel;

  // all zero is a bubble
  typedef struct packed {
    rv32i_opcode   opcode;
    alu_ops        alu_op;
    alumux1_sel    alumux1;
    alumux2_sel    alumux2;
    regfilemux_sel regfilemux;
    branch_funct3  cmp_op;
    logic          load_regfile;
    logic          mem_read;
    logic          mem_write;
    logic          is_branch;
    logic          is_jal;
    logic          is_jalr;
  } ctrl_word;

endpackage

// File: hw/pipe_ctrl_if.sv
/* pipe_ctrl_if: hazard information from the datapath and the
   forwarding, stall and flush controls returned by the hazard unit */
`timescale 1ns/1ps

interface pipe_ctrl_if;
  import rv32i_types::*;

  logic [4:0] idex_rs1;
  logic [4:0] idex_rs2;
  logic [4:0] ifid_rs1;  // zero when the ID instruction has no rs1
  logic [4:0] ifid_rs2;
  logic [4:0] exmem_rd;
  logic       exmem_load_regfile;
  logic [4:0] memwb_rd;
  logic       memwb_load_regfile;
  logic       idex_mem_read;
  logic [4:0] idex_rd;
  logic       ex_redirect; // taken branch or jump in EX

  fwd_sel fwd_a;
  fwd_sel fwd_b;
  logic   stall;
  logic   flush;

  modport dp (
    output idex_rs1, idex_rs2, ifid_rs1, ifid_rs2, exmem_rd, exmem_load_regfile,
    output memwb_rd, memwb_load_regfile, idex_mem_read, idex_rd, ex_redirect,
    input  fwd_a, fwd_b, stall, flush
  );

  modport hz (
    input  idex_rs1, idex_rs2, ifid_rs1, ifid_rs2, exmem_rd, exmem_load_regfile,
    input  memwb_rd, memwb_load_regfile, idex_mem_read, idex_rd, ex_redirect,
    output fwd_a, fwd_b, stall, flush
  );
endinterface

// File: hw/control_rom.sv
/* control_rom: decodes the instruction in ID into a control word.
   anything outside the supported subset becomes a bubble */
`timescale 1ns/1ps

module control_rom (
  input  rv32i_types::rv32i_opcode opcode,
  input  logic [2:0]               funct3,
  input  logic [6:0]               funct7,
  output rv32i_types::ctrl_word    idex_ctrl_word
);
  import rv32i_types::*;

  // funct3 to ALU operation; funct7[5] picks the alternate form
  function automatic alu_ops arith_op(input logic [2:0] f3, input logic sub_en,
                                      input logic sra_en);
    case (f3)
      3'b000:  arith_op = sub_en ? alu_sub : alu_add;
      3'b001:  arith_op = alu_sll;
      3'b010:  arith_op = alu_slt;
      3'b011:  arith_op = alu_sltu;
      3'b100:  arith_op = alu_xor;
      3'b101:  arith_op = sra_en ? alu_sra : alu_srl;
      3'b110:  arith_op = alu_or;
      default: arith_op = alu_and;
    endcase
  endfunction

  always_comb begin
    idex_ctrl_word = '0;
    idex_ctrl_word.opcode = opcode;
    case (opcode)
      op_lui: begin
        idex_ctrl_word.alumux2 = alumux2_imm;
        idex_ctrl_word.alu_op = alu_pass_b;
        idex_ctrl_word.load_regfile = 1'b1;
      end
      op_auipc: begin
        idex_ctrl_word.alumux1 = alumux1_pc;
        idex_ctrl_word.alumux2 = alumux2_imm;
        idex_ctrl_word.load_regfile = 1'b1;
      end
      op_jal: begin
        idex_ctrl_word.regfilemux = rfmux_pc_plus4; // target from the pc adder
        idex_ctrl_word.load_regfile = 1'b1;
        idex_ctrl_word.is_jal = 1'b1;
      end
      op_jalr: begin
        idex_ctrl_word.alumux2 = alumux2_imm;       // rs1 + imm in the ALU
        idex_ctrl_word.regfilemux = rfmux_pc_plus4;
        idex_ctrl_word.load_regfile = 1'b1;
        idex_ctrl_word.is_jalr = 1'b1;
      end
      op_br: begin
        idex_ctrl_word.cmp_op = branch_funct3'(funct3);
        idex_ctrl_word.is_branch = 1'b1;
      end
      op_load: begin
        if (funct3 == 3'b010) begin  // lw only
          idex_ctrl_word.alumux2 = alumux2_imm;
          idex_ctrl_word.regfilemux = rfmux_load;
          idex_ctrl_word.load_regfile = 1'b1;
          idex_ctrl_word.mem_read = 1'b1;
        end else begin
          idex_ctrl_word = '0;
        end
      end
      op_store: begin
        if (funct3 == 3'b010) begin  // sw only
          idex_ctrl_word.alumux2 = alumux2_imm;
          idex_ctrl_word.mem_write = 1'b1;
        end else begin
          idex_ctrl_word = '0;
        end
      end
      op_imm: begin
        idex_ctrl_word.alumux2 = alumux2_imm;
        idex_ctrl_word.alu_op = arith_op(funct3, 1'b0, funct7[5]);
        idex_ctrl_word.load_regfile = 1'b1;
      end
      op_reg: begin
        idex_ctrl_word.alu_op = arith_op(funct3, funct7[5], funct7[5]);
        idex_ctrl_word.load_regfile = 1'b1;
      end
      default: idex_ctrl_word = '0;
    endcase
  end

endmodule

// File: hw/regfile.sv
/* regfile: 32 x 32 register file, x0 reads as zero.
   a write in the same cycle is bypassed to the read ports */
`timescale 1ns/1ps

module regfile (
  input  logic        clk,
  input  logic        rst,
  input  logic        load,
  input  logic [4:0]  rd,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  input  logic [31:0] wdata,
  output logic [31:0] rs1_out,
  output logic [31:0] rs2_out
);
  logic [31:0] regs [32];
  logic        wr_en;

  assign wr_en = load && (rd != 5'd0); // x0 never written

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[rd] <= wdata;
    end
  end

  assign rs1_out = (wr_en && rd == rs1) ? wdata : regs[rs1];
  assign rs2_out = (wr_en && rd == rs2) ? wdata : regs[rs2];

endmodule

// File: hw/alu.sv
/* alu: arithmetic and logic operations plus the branch comparator */
`timescale 1ns/1ps

module alu (
  input  rv32i_types::alu_ops       aluop,
  input  rv32i_types::branch_funct3 cmpop,
  input  logic [31:0]               a,
  input  logic [31:0]               b,
  output logic [31:0]               f,
  output logic                      br_en
);
  import rv32i_types::*;

  always_comb begin
    case (aluop)
      alu_sub:    f = a - b;
      alu_sll:    f = a << b[4:0];
      alu_slt:    f = {31'd0, $signed(a) < $signed(b)};
      alu_sltu:   f = {31'd0, a < b};
      alu_xor:    f = a ^ b;
      alu_srl:    f = a >> b[4:0];
      alu_sra:    f = $unsigned($signed(a) >>> b[4:0]);
      alu_or:     f = a | b;
      alu_and:    f = a & b;
      alu_pass_b: f = b;
      default:    f = a + b;   // add, also address and jalr target
    endcase
  end

  // a and b are the forwarded rs1/rs2 on a branch
  always_comb begin
    case (cmpop)
      beq:     br_en = (a == b);
      bne:     br_en = (a != b);
      blt:     br_en = ($signed(a) < $signed(b));
      bge:     br_en = ($signed(a) >= $signed(b));
      bltu:    br_en = (a < b);
      bgeu:    br_en = (a >= b);
      default: br_en = 1'b0;
    endcase
  end

endmodule

// File: hw/hazard_unit.sv
/* hazard_unit: EX operand forwarding, load-use stall and
   the flush of IF/ID and ID/EX on a redirect from EX */
`timescale 1ns/1ps

module hazard_unit (
  pipe_ctrl_if.hz hz
);
  import rv32i_types::*;

  logic rs1_load_use;
  logic rs2_load_use;

  // newest producer wins, x0 never forwarded
  function automatic fwd_sel pick_fwd(input logic [4:0] rs,
                                      input logic [4:0] exmem_rd,
                                      input logic       exmem_ld,
                                      input logic [4:0] memwb_rd,
                                      input logic       memwb_ld);
    if (rs == 5'd0) begin
      pick_fwd = fwd_rf;
    end else if (exmem_ld && exmem_rd == rs) begin
      pick_fwd = fwd_exmem;
    end else if (memwb_ld && memwb_rd == rs) begin
      pick_fwd = fwd_memwb;
    end else begin
      pick_fwd = fwd_rf;
    end
  endfunction

  assign hz.fwd_a = pick_fwd(hz.idex_rs1, hz.exmem_rd, hz.exmem_load_regfile,
                             hz.memwb_rd, hz.memwb_load_regfile);
  assign hz.fwd_b = pick_fwd(hz.idex_rs2, hz.exmem_rd, hz.exmem_load_regfile,
                             hz.memwb_rd, hz.memwb_load_regfile);

  // load data only exists after MEM, so the consumer waits one cycle
  assign rs1_load_use = (hz.ifid_rs1 == hz.idex_rd);
  assign rs2_load_use = (hz.ifid_rs2 == hz.idex_rd);
  assign hz.stall = hz.idex_mem_read && (hz.idex_rd != 5'd0) &&
                    (rs1_load_use || rs2_load_use);

  assign hz.flush = hz.ex_redirect; // wrong-path fetches in IF and ID

endmodule

// File: hw/datapath.sv
/* datapath: PC, IF/ID, ID/EX, EX/MEM and MEM/WB registers with immediate
   generation, forwarding muxes, branch resolution in EX and writeback select */
`timescale 1ns/1ps

module datapath #(
  parameter logic [31:0] reset_pc = 32'h0000_0000
) (
  input  logic                     clk,
  input  logic                     rst,
  output rv32i_types::rv32i_opcode opcode,
  output logic [2:0]               funct3,
  output logic [6:0]               funct7,
  input  rv32i_types::ctrl_word    idex_ctrl_word,
  pipe_ctrl_if.dp                  pc_if,

  output logic [31:0]              icache_address,
  input  logic [31:0]              icache_rdata,
  output logic                     icache_read,

  output logic [31:0]              dcache_address,
  output logic [31:0]              dcache_wdata,
  output logic [3:0]               dcache_mbe,
  input  logic [31:0]              dcache_rdata,
  output logic                     dcache_read,
  output logic                     dcache_write
);
  import rv32i_types::*;

  logic [31:0] pc, pc_next;
  logic [31:0] ifid_pc, ifid_instr;
  logic [31:0] id_imm, rs1_data, rs2_data;
  logic        uses_rs1, uses_rs2;

  ctrl_word    idex_ctrl;
  logic [31:0] idex_pc, idex_imm, idex_rs1_data, idex_rs2_data;
  logic [4:0]  idex_rs1, idex_rs2, idex_rd;

  logic [31:0] fwd_a_data, fwd_b_data, alu_a, alu_b, alu_f;
  logic [31:0] br_target, ex_result;
  logic        br_en;
  pcmux_sel    pcmux;

  ctrl_word    exmem_ctrl, memwb_ctrl;
  logic [31:0] exmem_result, exmem_rs2;
  logic [31:0] memwb_result, memwb_rdata, wb_data;
  logic [4:0]  exmem_rd, memwb_rd;

  function automatic logic [31:0] fwd_mux(input fwd_sel sel, input logic [31:0] rf_val,
                                          input logic [31:0] exmem_val,
                                          input logic [31:0] memwb_val);
    case (sel)
      fwd_exmem: fwd_mux = exmem_val;
      fwd_memwb: fwd_mux = memwb_val;
      default:   fwd_mux = rf_val;
    endcase
  endfunction

  // IF
  assign icache_address = pc;
  assign icache_read = !pc_if.stall;

  always_comb begin
    case (pcmux)
      pcmux_target: pc_next = br_target;
      pcmux_jalr:   pc_next = {alu_f[31:1], 1'b0};
      default:      pc_next = pc_if.stall ? pc : pc + 32'd4;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= reset_pc;
    end else begin
      pc <= pc_next;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || pc_if.flush) begin
      ifid_instr <= '0;           // opcode 0 decodes to a bubble
    end else if (!pc_if.stall) begin
      ifid_instr <= icache_rdata;
    end
  end

  always_ff @(posedge clk) begin
    if (!pc_if.stall) begin
      ifid_pc <= pc;
    end
  end

  // ID
  assign opcode = rv32i_opcode'(ifid_instr[6:0]);
  assign funct3 = ifid_instr[14:12];
  assign funct7 = ifid_instr[31:25];

  always_comb begin
    case (opcode)
      op_store: id_imm = {{20{ifid_instr[31]}}, ifid_instr[31:25], ifid_instr[11:7]};
      op_br:    id_imm = {{19{ifid_instr[31]}}, ifid_instr[31], ifid_instr[7],
                          ifid_instr[30:25], ifid_instr[11:8], 1'b0};
      op_lui, op_auipc: id_imm = {ifid_instr[31:12], 12'h000};
      op_jal:   id_imm = {{11{ifid_instr[31]}}, ifid_instr[31], ifid_instr[19:12],
                          ifid_instr[20], ifid_instr[30:21], 1'b0};
      default:  id_imm = {{20{ifid_instr[31]}}, ifid_instr[31:20]}; // I-type
    endcase
  end

  // only real source operands may cause a load-use stall
  assign uses_rs1 = !(opcode inside {op_lui, op_auipc, op_jal});
  assign uses_rs2 = opcode inside {op_br, op_store, op_reg};
  assign pc_if.ifid_rs1 = uses_rs1 ? ifid_instr[19:15] : 5'd0;
  assign pc_if.ifid_rs2 = uses_rs2 ? ifid_instr[24:20] : 5'd0;

  regfile rf (
    .clk(clk),
    .rst(rst),
    .load(memwb_ctrl.load_regfile),
    .rd(memwb_rd),
    .rs1(ifid_instr[19:15]),
    .rs2(ifid_instr[24:20]),
    .wdata(wb_data),
    .rs1_out(rs1_data),
    .rs2_out(rs2_data)
  );

  always_ff @(posedge clk) begin
    if (rst || pc_if.flush || pc_if.stall) begin
      idex_ctrl <= '0;
    end else begin
      idex_ctrl <= idex_ctrl_word;
    end
  end

  always_ff @(posedge clk) begin
    idex_pc <= ifid_pc;
    idex_imm <= id_imm;
    idex_rs1_data <= rs1_data;
    idex_rs2_data <= rs2_data;
    idex_rs1 <= ifid_instr[19:15];
    idex_rs2 <= ifid_instr[24:20];
    idex_rd <= ifid_instr[11:7];
  end

  // EX
  assign pc_if.idex_rs1 = idex_rs1;
  assign pc_if.idex_rs2 = idex_rs2;
  assign pc_if.idex_rd = idex_rd;
  assign pc_if.idex_mem_read = idex_ctrl.mem_read;

  assign fwd_a_data = fwd_mux(pc_if.fwd_a, idex_rs1_data, exmem_result, wb_data);
  assign fwd_b_data = fwd_mux(pc_if.fwd_b, idex_rs2_data, exmem_result, wb_data);
  assign alu_a = (idex_ctrl.alumux1 == alumux1_pc) ? idex_pc : fwd_a_data;
  assign alu_b = (idex_ctrl.alumux2 == alumux2_imm) ? idex_imm : fwd_b_data;

  alu alu_ex (
    .aluop(idex_ctrl.alu_op),
    .cmpop(idex_ctrl.cmp_op),
    .a(alu_a),
    .b(alu_b),
    .f(alu_f),
    .br_en(br_en)
  );

  assign br_target = idex_pc + idex_imm; // branch and jal

  always_comb begin
    if (idex_ctrl.is_jalr) begin
      pcmux = pcmux_jalr;
    end else if (idex_ctrl.is_jal || (idex_ctrl.is_branch && br_en)) begin
      pcmux = pcmux_target;
    end else begin
      pcmux = pcmux_pc_plus4;
    end
  end
  assign pc_if.ex_redirect = (pcmux != pcmux_pc_plus4);

  // link value is resolved here so EX/MEM forwarding sees it
  assign ex_result = (idex_ctrl.regfilemux == rfmux_pc_plus4) ? idex_pc + 32'd4 : alu_f;

  always_ff @(posedge clk) begin
    if (rst) begin
      exmem_ctrl <= '0;
    end else begin
      exmem_ctrl <= idex_ctrl;
    end
  end

  always_ff @(posedge clk) begin
    exmem_result <= ex_result;
    exmem_rs2 <= fwd_b_data;   // store data
    exmem_rd <= idex_rd;
  end

  // MEM
  assign pc_if.exmem_rd = exmem_rd;
  assign pc_if.exmem_load_regfile = exmem_ctrl.load_regfile;

  assign dcache_address = exmem_result;
  assign dcache_wdata = exmem_rs2;
  assign dcache_read = exmem_ctrl.mem_read;
  assign dcache_write = exmem_ctrl.mem_write;
  assign dcache_mbe = (exmem_ctrl.opcode == op_store) ? 4'b1111 : 4'b0000;

  always_ff @(posedge clk) begin
    if (rst) begin
      memwb_ctrl <= '0;
    end else begin
      memwb_ctrl <= exmem_ctrl;
    end
  end

  always_ff @(posedge clk) begin
    memwb_result <= exmem_result;
    memwb_rdata <= dcache_rdata;
    memwb_rd <= exmem_rd;
  end

  // WB
  assign pc_if.memwb_rd = memwb_rd;
  assign pc_if.memwb_load_regfile = memwb_ctrl.load_regfile;
  assign wb_data = (memwb_ctrl.regfilemux == rfmux_load) ? memwb_rdata : memwb_result;

endmodule

// File: hw/mp3.sv
/* mp3: top level of the pipelined RV32I core.
   connects the datapath, control ROM and hazard unit to the cache ports */
`timescale 1ns/1ps

module mp3 #(
  parameter logic [31:0] reset_pc = 32'h0000_0000
) (
  input  logic        clk,
  input  logic        rst,

  output logic [31:0] icache_address,
  output logic [31:0] icache_wdata,
  input  logic [31:0] icache_rdata,
  output logic        icache_read,
  output logic        icache_write,

  output logic [31:0] dcache_address,
  output logic [31:0] dcache_wdata,
  output logic [3:0]  dcache_mbe,
  input  logic [31:0] dcache_rdata,
  output logic        dcache_read,
  output logic        dcache_write
);
  import rv32i_types::*;

  rv32i_opcode opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  ctrl_word    ctrl;       // decoded ID instruction

  pipe_ctrl_if pc_if ();

  // instruction memory is read only
  assign icache_write = 1'b0;
  assign icache_wdata = '0;

  datapath #(
    .reset_pc(reset_pc)
  ) dpath (
    .clk(clk),
    .rst(rst),
    .opcode(opcode),
    .funct3(funct3),
    .funct7(funct7),
    .idex_ctrl_word(ctrl),
    .pc_if(pc_if),
    .icache_address(icache_address),
    .icache_rdata(icache_rdata),
    .icache_read(icache_read),
    .dcache_address(dcache_address),
    .dcache_wdata(dcache_wdata),
    .dcache_mbe(dcache_mbe),
    .dcache_rdata(dcache_rdata),
    .dcache_read(dcache_read),
    .dcache_write(dcache_write)
  );

  control_rom ctrl_rom (
    .opcode(opcode),
    .funct3(funct3),
    .funct7(funct7),
    .idex_ctrl_word(ctrl)
  );

  hazard_unit hz_unit (
    .hz(pc_if)
  );

endmodule

// File: test/tb_mp3.sv
/* tb_mp3: directed testbench for the pipelined RV32I core.
   models the instruction ROM and data RAM, assembles small programs and checks memory */
`timescale 1ns/1ps

module tb_mp3;
  import rv32i_types::*;

  localparam logic [31:0] reset_pc = 32'h0000_0080;
  localparam int max_cycles = 2000;  // five runs of at most 300 cycles, resets and margin
  localparam int run_limit = 300;

  logic        clk = 1'b0;
  logic        rst;
  logic [31:0] icache_address, icache_wdata, icache_rdata;
  logic        icache_read, icache_write;
  logic [31:0] dcache_address, dcache_wdata, dcache_rdata;
  logic [3:0]  dcache_mbe;
  logic        dcache_read, dcache_write;

  logic [31:0] imem [1024];
  logic [31:0] dmem [256];
  logic        fill_data;           // reload the data RAM pattern at the next edge
  logic [9:0]  prog_len;
  logic [31:0] halt_addr;
  logic        write_seen;
  logic [31:0] first_write_addr;
  int          cycle_count = 0;
  int          hold_count = 0;      // cycles with icache_read low since reset
  int          read_count = 0;      // cycles with dcache_read high since reset
  string       cur_test = "reset";

  mp3 #(
    .reset_pc(reset_pc)
  ) uut (
    .clk(clk),
    .rst(rst),
    .icache_address(icache_address),
    .icache_wdata(icache_wdata),
    .icache_rdata(icache_rdata),
    .icache_read(icache_read),
    .icache_write(icache_write),
    .dcache_address(dcache_address),
    .dcache_wdata(dcache_wdata),
    .dcache_mbe(dcache_mbe),
    .dcache_rdata(dcache_rdata),
    .dcache_read(dcache_read),
    .dcache_write(dcache_write)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] fill_word(input logic [7:0] idx);
    fill_word = {16'ha5a5, 6'd0, idx, 2'b00};
  endfunction

  // memories answer in the same cycle, writes land at the edge
  assign icache_rdata = imem[icache_address[11:2]];
  assign dcache_rdata = dmem[dcache_address[9:2]];

  always @(posedge clk) begin
    if (fill_data) begin
      for (int i = 0; i < 256; i++) begin
        dmem[8'(i)] <= fill_word(8'(i));
      end
    end else if (dcache_write && dcache_mbe == 4'b1111) begin
      dmem[dcache_address[9:2]] <= dcache_wdata;
    end
  end

  // first store after reset, sampled mid-cycle
  always @(negedge clk) begin
    if (rst) begin
      write_seen <= 1'b0;
    end else if (dcache_write && !write_seen) begin
      write_seen <= 1'b1;
      first_write_addr <= dcache_address;
    end
  end

  // cache port rules while the core runs
  always @(negedge clk) begin
    if (rst) begin
      hold_count <= 0;
      read_count <= 0;
    end else begin
      if (!icache_read) begin
        hold_count <= hold_count + 1;
      end
      if (dcache_read) begin
        read_count <= read_count + 1;
      end
      check_value(cur_test, "icache_write", 32'd0, {31'd0, icache_write});
      check_value(cur_test, "icache_wdata", 32'd0, icache_wdata);
      check_value(cur_test, "dcache_mbe", dcache_write ? 32'hf : 32'h0, {28'd0, dcache_mbe});
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      $display("timeout: simulation ran past %0d cycles", max_cycles);
      $display("STATUS: FAIL");
      $fatal(1, "global cycle limit reached");
    end
  end

  function automatic logic [31:0] addr_of(input logic [9:0] n);
    addr_of = reset_pc + {20'd0, n, 2'b00};
  endfunction

  function automatic logic [31:0] sext(input logic [11:0] imm);
    sext = {{20{imm[11]}}, imm};
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    r_type = {f7, rs2, rs1, f3, rd, op_reg};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input rv32i_opcode op);
    i_type = {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
    s_type = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op_store};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    b_type = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_br};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                         input rv32i_opcode op);
    u_type = {imm, rd, op};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
    j_type = {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
  endfunction

  // RV32I result rules, alt is funct7 bit 5
  function automatic logic [31:0] expected_result(input logic [2:0] f3, input logic alt,
                                                  input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0:    expected_result = alt ? a - b : a + b;
      3'd1:    expected_result = a << b[4:0];
      3'd2:    expected_result = {31'd0, $signed(a) < $signed(b)};
      3'd3:    expected_result = {31'd0, a < b};
      3'd4:    expected_result = a ^ b;
      // sra fills the vacated upper bits with the sign
      3'd5:    expected_result = (a >> b[4:0]) |
                                 ((alt && a[31]) ? ~(32'hffff_ffff >> b[4:0]) : 32'd0);
      3'd6:    expected_result = a | b;
      default: expected_result = a & b;
    endcase
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
    case (f3)
      3'd0:    branch_taken = (a == b);
      3'd1:    branch_taken = (a != b);
      3'd4:    branch_taken = ($signed(a) < $signed(b));
      3'd5:    branch_taken = ($signed(a) >= $signed(b));
      3'd6:    branch_taken = (a < b);
      default: branch_taken = (a >= b);
    endcase
  endfunction

  task automatic emit(input logic [31:0] instr);
    logic [9:0] idx;
    idx = reset_pc[11:2] + prog_len;
    imem[idx] = instr;
    prog_len = prog_len + 10'd1;
  endtask

  task automatic store(input logic [4:0] rs2, input logic [11:0] off);
    emit(s_type(off, rs2, 5'd0));
  endtask

  task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
    logic [31:0] upper;
    upper = value + 32'h800;  // compensates the sign of the addi immediate
    emit(u_type(upper[31:12], rd, op_lui));
    emit(i_type(value[11:0], rd, 3'b000, rd, op_imm));
  endtask

  task automatic append_halt();
    halt_addr = addr_of(prog_len);
    emit(j_type(21'd0, 5'd0));  // jal x0, 0
  endtask

  task automatic clear_program();
    for (int i = 0; i < 1024; i++) begin
      imem[10'(i)] = '0;
    end
    prog_len = '0;
  endtask

  task automatic start_reset();
    @(posedge clk);
    #1;
    rst = 1'b1;
    fill_data = 1'b1;
  endtask

  task automatic release_reset();
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    fill_data = 1'b0;
  endtask

  task automatic run_to_halt();
    int n;
    n = 0;
    while (icache_address != halt_addr) begin
      @(posedge clk);
      #1;
      n++;
      if (n > run_limit) begin
        $display("timeout: halt loop at 0x%08h not fetched in %0d cycles", halt_addr, run_limit);
        $display("STATUS: FAIL");
        $fatal(1, "program did not reach its halt loop");
      end
    end
    repeat (5) @(posedge clk);  // drain stores still in flight
    #1;
  endtask

  task automatic check_value(input string test, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
    assert (actual == expected) else begin
      $display("ERROR %s: %s expected 0x%08h actual 0x%08h", test, what, expected, actual);
      $display("STATUS: FAIL");
      $fatal(1, "value check failed");
    end
  endtask

  task automatic check_word(input string test, input logic [11:0] addr,
                            input logic [31:0] expected);
    check_value(test, $sformatf("word at 0x%03h", addr), expected, dmem[addr[9:2]]);
  endtask

  task automatic alu_test();
    logic [31:0] a, b, rnd;
    logic [31:0] exp_r [10];
    logic [31:0] exp_i [10];
    logic [2:0]  f3;
    logic        alt;
    logic [11:0] imm;
    cur_test = "alu";
    start_reset();
    clear_program();
    a = $urandom;
    b = $urandom;
    load_const(5'd1, a);
    load_const(5'd2, b);
    for (int k = 0; k < 10; k++) begin
      rnd = $urandom;
      f3 = (k < 8) ? 3'(k) : ((k == 8) ? 3'd0 : 3'd5);  // then sub and sra
      alt = (k >= 8);
      if (f3 == 3'd1 || f3 == 3'd5) begin
        imm = {1'b0, k == 9, 5'd0, rnd[4:0]};
      end else begin
        imm = rnd[11:0];
      end
      emit(r_type(alt ? 7'h20 : 7'h00, 5'd2, 5'd1, f3, 5'd3));
      store(5'd3, 12'(32'h100 + 8 * k));
      emit(i_type(imm, 5'd3, f3, 5'd5, op_imm));  // x3 forwarded from MEM/WB
      store(5'd5, 12'(32'h104 + 8 * k));
      exp_r[k] = expected_result(f3, alt, a, b);
      exp_i[k] = expected_result(f3, k == 9, exp_r[k], sext(imm));
    end
    append_halt();
    release_reset();
    run_to_halt();
    for (int k = 0; k < 10; k++) begin
      check_word("alu", 12'(32'h100 + 8 * k), exp_r[k]);
      check_word("alu", 12'(32'h104 + 8 * k), exp_i[k]);
    end
    check_value("alu", "fetch stall cycles", 32'd0, 32'(hold_count));
    check_value("alu", "dcache read cycles", 32'd0, 32'(read_count));
  endtask

  task automatic load_use_test();
    logic [31:0] v, w;
    cur_test = "load_use";
    start_reset();
    clear_program();
    v = $urandom;
    w = $urandom;
    load_const(5'd1, v);
    load_const(5'd4, w);
    store(5'd1, 12'h200);
    emit(i_type(12'h200, 5'd0, 3'b010, 5'd2, op_load));
    emit(r_type(7'h00, 5'd4, 5'd2, 3'b000, 5'd3));  // needs the load result at once
    store(5'd3, 12'h204);
    append_halt();
    release_reset();
    run_to_halt();
    check_word("load_use", 12'h200, v);
    check_word("load_use", 12'h204, v + w);
    check_value("load_use", "fetch stall cycles", 32'd1, 32'(hold_count));
    check_value("load_use", "dcache read cycles", 32'd1, 32'(read_count));
  endtask

  task automatic branch_test();
    logic [2:0]  f3_list [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    logic [31:0] a [6];
    logic [31:0] b [6];
    logic [31:0] rnd, mark;
    logic [11:0] off;
    cur_test = "branch";
    start_reset();
    clear_program();
    mark = 32'h0bad_f00d;
    load_const(5'd7, mark);
    for (int i = 0; i < 6; i++) begin
      rnd = $urandom;
      a[i] = $urandom;
      b[i] = rnd[0] ? a[i] : $urandom;  // equal operands half the time
      load_const(5'd1, a[i]);
      load_const(5'd2, b[i]);
      emit(b_type(13'd12, 5'd2, 5'd1, f3_list[i]));
      store(5'd7, 12'(32'h200 + 16 * i));  // shadow of a taken branch
      store(5'd7, 12'(32'h204 + 16 * i));
      emit(i_type(12'd1, 5'd9, 3'b000, 5'd9, op_imm));  // target
    end
    store(5'd9, 12'h2f0);
    append_halt();
    release_reset();
    run_to_halt();
    for (int i = 0; i < 6; i++) begin
      off = 12'(32'h200 + 16 * i);
      check_word("branch", off,
                 branch_taken(f3_list[i], a[i], b[i]) ? fill_word(off[9:2]) : mark);
      off = 12'(32'h204 + 16 * i);
      check_word("branch", off,
                 branch_taken(f3_list[i], a[i], b[i]) ? fill_word(off[9:2]) : mark);
    end
    check_word("branch", 12'h2f0, 32'd6);
  endtask

  task automatic jump_test();
    cur_test = "jump";
    start_reset();
    clear_program();
    emit(i_type(12'h055, 5'd0, 3'b000, 5'd7, op_imm));   // 0 marker
    emit(j_type(21'd12, 5'd1));                          // 1 jal to 4
    store(5'd7, 12'h300);                                // 2
    store(5'd7, 12'h304);                                // 3
    store(5'd1, 12'h308);                                // 4
    emit(u_type(20'd0, 5'd5, op_auipc));                 // 5
    emit(i_type(12'd16, 5'd5, 3'b000, 5'd6, op_jalr));   // 6 jalr to 9
    store(5'd7, 12'h30c);                                // 7
    store(5'd7, 12'h310);                                // 8
    store(5'd6, 12'h314);                                // 9
    store(5'd5, 12'h318);                                // 10
    append_halt();
    release_reset();
    run_to_halt();
    check_word("jump", 12'h300, fill_word(8'hc0));
    check_word("jump", 12'h304, fill_word(8'hc1));
    check_word("jump", 12'h308, addr_of(10'd1) + 32'd4);
    check_word("jump", 12'h30c, fill_word(8'hc3));
    check_word("jump", 12'h310, fill_word(8'hc4));
    check_word("jump", 12'h314, addr_of(10'd6) + 32'd4);
    check_word("jump", 12'h318, addr_of(10'd5));
  endtask

  task automatic x0_reset_test();
    cur_test = "x0_reset";
    start_reset();
    clear_program();
    emit(i_type(12'd123, 5'd0, 3'b000, 5'd0, op_imm));
    emit(r_type(7'h00, 5'd0, 5'd0, 3'b000, 5'd3));
    store(5'd3, 12'h380);
    emit(u_type(20'habcde, 5'd0, op_lui));
    emit(i_type(12'd0, 5'd0, 3'b000, 5'd4, op_imm));
    store(5'd4, 12'h384);
    store(5'd0, 12'h388);
    append_halt();
    release_reset();
    repeat (6) @(posedge clk);  // stop with stores in the pipeline
    start_reset();
    release_reset();
    check_value("x0_reset", "first fetch address", reset_pc, icache_address);
    run_to_halt();
    check_value("x0_reset", "write seen after reset", 32'd1, {31'd0, write_seen});
    check_value("x0_reset", "first write address", 32'h380, first_write_addr);
    check_word("x0_reset", 12'h380, 32'd0);
    check_word("x0_reset", 12'h384, 32'd0);
    check_word("x0_reset", 12'h388, 32'd0);
  endtask

  initial begin
    rst = 1'b1;
    fill_data = 1'b1;
    prog_len = '0;
    halt_addr = '0;
    void'($urandom(32'h931f6e3f));
    clear_program();
    alu_test();
    load_use_test();
    branch_test();
    jump_test();
    x0_reset_test();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

// File: mp3.f
hw/rv32i_types.sv
hw/pipe_ctrl_if.sv
hw/control_rom.sv
hw/regfile.sv
hw/alu.sv
hw/hazard_unit.sv
hw/datapath.sv
hw/mp3.sv
test/tb_mp3.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the mp3 testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_mp3 -f mp3.f -Mdir obj_dir -o sim_mp3
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

./obj_dir/sim_mp3 > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -qx "STATUS: PASS" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
